// File: logic/isaPkg.sv
package isaPkg;

  localparam int XLEN = 32;
  localparam int REG_INDEX_WIDTH = 5;
  localparam int FUNCT3_WIDTH = 3;
  localparam int FUNCT7_WIDTH = 7;

  // Field positions inside a 32-bit instruction word
  localparam int RD_LSB = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;
  localparam int FUNCT7_LSB = 25;

  typedef enum logic [6:0] {
    OpRType = 7'b0110011,
    OpIType = 7'b0010011,
    OpLoad  = 7'b0000011,
    OpStore = 7'b0100011
  } opcodeT;

  localparam logic [FUNCT3_WIDTH-1:0] FUNCT3_ADD_SUB = 3'b000;
  localparam logic [FUNCT3_WIDTH-1:0] FUNCT3_SLL = 3'b001;
  localparam logic [FUNCT3_WIDTH-1:0] FUNCT3_SLT = 3'b010;
  localparam logic [FUNCT3_WIDTH-1:0] FUNCT3_SLTU = 3'b011;
  localparam logic [FUNCT3_WIDTH-1:0] FUNCT3_XOR = 3'b100;
  localparam logic [FUNCT3_WIDTH-1:0] FUNCT3_SRL_SRA = 3'b101;
  localparam logic [FUNCT3_WIDTH-1:0] FUNCT3_OR = 3'b110;
  localparam logic [FUNCT3_WIDTH-1:0] FUNCT3_AND = 3'b111;
  // lw and sw
  localparam logic [FUNCT3_WIDTH-1:0] FUNCT3_WORD = 3'b010;

  localparam logic [FUNCT7_WIDTH-1:0] FUNCT7_ALT = 7'b0100000;

  // addi x0, x0, 0
  localparam logic [XLEN-1:0] NOP_INSTRUCTION = 32'h0000_0013;

endpackage

// File: logic/pipelinePkg.sv
package pipelinePkg;

  typedef enum logic [1:0] {
    AluOpMem   = 2'b00,
    AluOpRType = 2'b10,
    AluOpIType = 2'b11
  } aluOpT;

  typedef enum logic [3:0] {
    AluAdd,
    AluSub,
    AluAnd,
    AluOr,
    AluXor,
    AluSlt,
    AluSltu,
    AluSll,
    AluSrl,
    AluSra
  } aluCtrlT;

  typedef enum logic [1:0] {
    FwdNone      = 2'b00,
    FwdWriteback = 2'b01,
    FwdMemory    = 2'b10
  } forwardSelT;

  localparam int IMEM_DEPTH = 256;
  localparam int DMEM_DEPTH = 256;
  localparam int IMEM_ADDR_WIDTH = 8;

endpackage

// File: logic/ForwardingUnit.sv
`timescale 1ns/1ns

module ForwardingUnit (
  input  logic [isaPkg::REG_INDEX_WIDTH-1:0] readIndex,
  input  logic [isaPkg::REG_INDEX_WIDTH-1:0] memWriteIndex,
  input  logic memRegWrite,
  input  logic [isaPkg::REG_INDEX_WIDTH-1:0] wbWriteIndex,
  input  logic wbRegWrite,
  output pipelinePkg::forwardSelT forwardSelect
);

  // Memory stage holds the younger result, so it wins
  always_comb begin
    if (readIndex == '0) begin
      forwardSelect = pipelinePkg::FwdNone;
    end else if (memRegWrite && (memWriteIndex == readIndex)) begin
      forwardSelect = pipelinePkg::FwdMemory;
    end else if (wbRegWrite && (wbWriteIndex == readIndex)) begin
      forwardSelect = pipelinePkg::FwdWriteback;
    end else begin
      forwardSelect = pipelinePkg::FwdNone;
    end
  end

endmodule

// File: logic/RegisterFile.sv
`timescale 1ns/1ns

module RegisterFile (
  input  logic clk,
  input  logic rstN,
  input  logic [isaPkg::REG_INDEX_WIDTH-1:0] rs1Index,
  input  logic [isaPkg::REG_INDEX_WIDTH-1:0] rs2Index,
  output logic [isaPkg::XLEN-1:0] rs1Data,
  output logic [isaPkg::XLEN-1:0] rs2Data,
  input  logic [isaPkg::REG_INDEX_WIDTH-1:0] writeIndex,
  input  logic [isaPkg::XLEN-1:0] writeData,
  input  logic writeEnable
);

  logic [isaPkg::XLEN-1:0] registers [2**isaPkg::REG_INDEX_WIDTH];

  function automatic logic [isaPkg::XLEN-1:0] readPort(
    input logic [isaPkg::REG_INDEX_WIDTH-1:0] index
  );
    if (index == '0) begin
      return '0;
    end
    // Same-cycle write seen by decode
    if (writeEnable && (writeIndex == index)) begin
      return writeData;
    end
    return registers[index];
  endfunction

  always_ff @(posedge clk) begin
    if (!rstN) begin
      registers <= '{default: '0};
    end else if (writeEnable && (writeIndex != '0)) begin
      registers[writeIndex] <= writeData;
    end
  end

  assign rs1Data = readPort(rs1Index);
  assign rs2Data = readPort(rs2Index);

endmodule

// File: logic/MemoryHandler.sv
`timescale 1ns/1ns

module MemoryHandler (
  input  logic clk,
  input  logic progWriteEnable,
  input  logic [pipelinePkg::IMEM_ADDR_WIDTH-1:0] progAddress,
  input  logic [isaPkg::XLEN-1:0] progData,
  input  logic [isaPkg::XLEN-1:0] pc,
  output logic [isaPkg::XLEN-1:0] instruction,
  input  logic [isaPkg::XLEN-1:0] dataAddress,
  input  logic [isaPkg::XLEN-1:0] dataWriteData,
  input  logic dataWriteEnable,
  input  logic dataReadEnable,
  output logic [isaPkg::XLEN-1:0] dataReadData
);

  logic [isaPkg::XLEN-1:0] instructionMem [pipelinePkg::IMEM_DEPTH];
  logic [isaPkg::XLEN-1:0] dataMem [pipelinePkg::DMEM_DEPTH];
  logic [pipelinePkg::IMEM_ADDR_WIDTH-1:0] pcWordIndex;
  logic [$clog2(pipelinePkg::DMEM_DEPTH)-1:0] dataWordIndex;

  // Word addressed, byte offset dropped
  assign pcWordIndex = pc[2 +: $bits(pcWordIndex)];
  assign dataWordIndex = dataAddress[2 +: $bits(dataWordIndex)];

  always_ff @(posedge clk) begin
    if (progWriteEnable) begin
      instructionMem[progAddress] <= progData;
    end
  end

  assign instruction = instructionMem[pcWordIndex];

  always_ff @(posedge clk) begin
    if (dataWriteEnable) begin
      dataMem[dataWordIndex] <= dataWriteData;
    end
  end

  assign dataReadData = dataReadEnable ? dataMem[dataWordIndex] : '0;

endmodule

// File: logic/FetchStage.sv
`timescale 1ns/1ns

module FetchStage (
  input  logic clk,
  input  logic rstN,
  input  logic stall,
  input  logic [isaPkg::XLEN-1:0] instruction,
  output logic [isaPkg::XLEN-1:0] pc,
  output logic [isaPkg::XLEN-1:0] idInstruction
);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= '0;
    end else if (!stall) begin
      pc <= pc + isaPkg::XLEN'(4);
    end
  end

  // IF/ID barrier holds its word for the stall cycle
  always_ff @(posedge clk) begin
    if (!rstN) begin
      idInstruction <= isaPkg::NOP_INSTRUCTION;
    end else if (!stall) begin
      idInstruction <= instruction;
    end
  end

endmodule

// File: logic/DecodeStage.sv
`timescale 1ns/1ns

module DecodeStage (
  input  logic clk,
  input  logic rstN,
  input  logic [isaPkg::XLEN-1:0] idInstruction,
  output logic [isaPkg::REG_INDEX_WIDTH-1:0] rs1Index,
  output logic [isaPkg::REG_INDEX_WIDTH-1:0] rs2Index,
  input  logic [isaPkg::XLEN-1:0] rs1Data,
  input  logic [isaPkg::XLEN-1:0] rs2Data,
  input  logic [isaPkg::REG_INDEX_WIDTH-1:0] exWriteIndexFeedback,
  input  logic exMemReadFeedback,
  output logic stall,
  output logic [isaPkg::XLEN-1:0] exRs1Data,
  output logic [isaPkg::XLEN-1:0] exRs2Data,
  output logic [isaPkg::REG_INDEX_WIDTH-1:0] exRs1Index,
  output logic [isaPkg::REG_INDEX_WIDTH-1:0] exRs2Index,
  output logic [isaPkg::REG_INDEX_WIDTH-1:0] exWriteIndex,
  output logic [isaPkg::XLEN-1:0] exImmediate,
  output logic [isaPkg::FUNCT3_WIDTH-1:0] exFunct3,
  output logic [isaPkg::FUNCT7_WIDTH-1:0] exFunct7,
  output pipelinePkg::aluOpT exAluOp,
  output logic exAluSrc,
  output logic exMemRead,
  output logic exMemWrite,
  output logic exMemToReg,
  output logic exRegWrite
);

  isaPkg::opcodeT opcode;
  logic [isaPkg::REG_INDEX_WIDTH-1:0] writeIndex;
  logic [isaPkg::XLEN-1:0] immediate;
  pipelinePkg::aluOpT aluOp;
  logic aluSrc;
  logic memRead;
  logic memWrite;
  logic memToReg;
  logic regWrite;
  logic usesRs2;

  assign opcode = isaPkg::opcodeT'(idInstruction[$bits(isaPkg::opcodeT)-1:0]);
  assign rs1Index = idInstruction[isaPkg::RS1_LSB +: isaPkg::REG_INDEX_WIDTH];
  assign rs2Index = idInstruction[isaPkg::RS2_LSB +: isaPkg::REG_INDEX_WIDTH];
  assign writeIndex = idInstruction[isaPkg::RD_LSB +: isaPkg::REG_INDEX_WIDTH];

  always_comb begin
    aluOp = pipelinePkg::AluOpMem;
    aluSrc = 1'b0;
    memRead = 1'b0;
    memWrite = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    case (opcode)
      isaPkg::OpRType: begin
        aluOp = pipelinePkg::AluOpRType;
        regWrite = 1'b1;
      end
      isaPkg::OpIType: begin
        aluOp = pipelinePkg::AluOpIType;
        aluSrc = 1'b1;
        regWrite = 1'b1;
      end
      isaPkg::OpLoad: begin
        aluSrc = 1'b1;
        memRead = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
      end
      isaPkg::OpStore: begin
        aluSrc = 1'b1;
        memWrite = 1'b1;
      end
      default: ;
    endcase
    // Writes to x0 are dropped here
    if (writeIndex == '0) begin
      regWrite = 1'b0;
    end
  end

  // S-type splits the offset around rd
  assign immediate = (opcode == isaPkg::OpStore) ?
                     {{20{idInstruction[31]}}, idInstruction[31:25], idInstruction[11:7]} :
                     {{20{idInstruction[31]}}, idInstruction[31:20]};

  assign usesRs2 = (opcode == isaPkg::OpRType) || (opcode == isaPkg::OpStore);

  // Load in execute feeding this instruction
  assign stall = exMemReadFeedback && (exWriteIndexFeedback != '0) &&
                 ((exWriteIndexFeedback == rs1Index) ||
                  (usesRs2 && (exWriteIndexFeedback == rs2Index)));

  always_ff @(posedge clk) begin
    exRs1Data <= rs1Data;
    exRs2Data <= rs2Data;
    exRs1Index <= rs1Index;
    exRs2Index <= rs2Index;
    exWriteIndex <= writeIndex;
    exImmediate <= immediate;
    exFunct3 <= idInstruction[isaPkg::FUNCT3_LSB +: isaPkg::FUNCT3_WIDTH];
    exFunct7 <= idInstruction[isaPkg::FUNCT7_LSB +: isaPkg::FUNCT7_WIDTH];
  end

  // Bubble on stall
  always_ff @(posedge clk) begin
    if (!rstN || stall) begin
      exAluOp <= pipelinePkg::AluOpMem;
      exAluSrc <= 1'b0;
      exMemRead <= 1'b0;
      exMemWrite <= 1'b0;
      exMemToReg <= 1'b0;
      exRegWrite <= 1'b0;
    end else begin
      exAluOp <= aluOp;
      exAluSrc <= aluSrc;
      exMemRead <= memRead;
      exMemWrite <= memWrite;
      exMemToReg <= memToReg;
      exRegWrite <= regWrite;
    end
  end

endmodule

// File: logic/ExecuteStage.sv
`timescale 1ns/1ns

module ExecuteStage (
  input  logic clk,
  input  logic rstN,
  input  logic [isaPkg::XLEN-1:0] exRs1Data,
  input  logic [isaPkg::XLEN-1:0] exRs2Data,
  input  logic [isaPkg::REG_INDEX_WIDTH-1:0] exRs1Index,
  input  logic [isaPkg::REG_INDEX_WIDTH-1:0] exRs2Index,
  input  logic [isaPkg::REG_INDEX_WIDTH-1:0] exWriteIndex,
  input  logic [isaPkg::XLEN-1:0] exImmediate,
  input  logic [isaPkg::FUNCT3_WIDTH-1:0] exFunct3,
  input  logic [isaPkg::FUNCT7_WIDTH-1:0] exFunct7,
  input  pipelinePkg::aluOpT exAluOp,
  input  logic exAluSrc,
  input  logic exMemRead,
  input  logic exMemWrite,
  input  logic exMemToReg,
  input  logic exRegWrite,
  input  logic [isaPkg::XLEN-1:0] wbData,
  input  logic [isaPkg::REG_INDEX_WIDTH-1:0] wbWriteIndex,
  input  logic wbRegWrite,
  output logic [isaPkg::XLEN-1:0] memAluResult,
  output logic [isaPkg::XLEN-1:0] memWriteData,
  output logic [isaPkg::REG_INDEX_WIDTH-1:0] memWriteIndex,
  output logic memMemWrite,
  output logic memMemRead,
  output logic memMemToReg,
  output logic memRegWrite
);

  pipelinePkg::forwardSelT rs1Select;
  pipelinePkg::forwardSelT rs2Select;
  pipelinePkg::aluCtrlT aluCtrl;
  logic [isaPkg::XLEN-1:0] rs1Value;
  logic [isaPkg::XLEN-1:0] rs2Value;
  logic [isaPkg::XLEN-1:0] operandB;
  logic [$clog2(isaPkg::XLEN)-1:0] shamt;
  logic [isaPkg::XLEN-1:0] aluResult;

  ForwardingUnit u_Rs1ForwardingUnit (
    .readIndex(exRs1Index),
    .memWriteIndex(memWriteIndex),
    .memRegWrite(memRegWrite),
    .wbWriteIndex(wbWriteIndex),
    .wbRegWrite(wbRegWrite),
    .forwardSelect(rs1Select)
  );

  ForwardingUnit u_Rs2ForwardingUnit (
    .readIndex(exRs2Index),
    .memWriteIndex(memWriteIndex),
    .memRegWrite(memRegWrite),
    .wbWriteIndex(wbWriteIndex),
    .wbRegWrite(wbRegWrite),
    .forwardSelect(rs2Select)
  );

  assign rs1Value = (rs1Select == pipelinePkg::FwdMemory) ? memAluResult :
                    (rs1Select == pipelinePkg::FwdWriteback) ? wbData : exRs1Data;
  assign rs2Value = (rs2Select == pipelinePkg::FwdMemory) ? memAluResult :
                    (rs2Select == pipelinePkg::FwdWriteback) ? wbData : exRs2Data;
  assign operandB = exAluSrc ? exImmediate : rs2Value;
  assign shamt = operandB[$bits(shamt)-1:0];

  // No subi, so funct7 only matters for R-type add/sub and for shifts
  always_comb begin
    aluCtrl = pipelinePkg::AluAdd;
    if (exAluOp != pipelinePkg::AluOpMem) begin
      case (exFunct3)
        isaPkg::FUNCT3_ADD_SUB: begin
          if ((exAluOp == pipelinePkg::AluOpRType) && (exFunct7 == isaPkg::FUNCT7_ALT)) begin
            aluCtrl = pipelinePkg::AluSub;
          end
        end
        isaPkg::FUNCT3_SLL: aluCtrl = pipelinePkg::AluSll;
        isaPkg::FUNCT3_SLT: aluCtrl = pipelinePkg::AluSlt;
        isaPkg::FUNCT3_SLTU: aluCtrl = pipelinePkg::AluSltu;
        isaPkg::FUNCT3_XOR: aluCtrl = pipelinePkg::AluXor;
        isaPkg::FUNCT3_SRL_SRA: begin
          aluCtrl = (exFunct7 == isaPkg::FUNCT7_ALT) ? pipelinePkg::AluSra : pipelinePkg::AluSrl;
        end
        isaPkg::FUNCT3_OR: aluCtrl = pipelinePkg::AluOr;
        isaPkg::FUNCT3_AND: aluCtrl = pipelinePkg::AluAnd;
        default: aluCtrl = pipelinePkg::AluAdd;
      endcase
    end
  end

  always_comb begin
    case (aluCtrl)
      pipelinePkg::AluAdd: aluResult = rs1Value + operandB;
      pipelinePkg::AluSub: aluResult = rs1Value - operandB;
      pipelinePkg::AluAnd: aluResult = rs1Value & operandB;
      pipelinePkg::AluOr: aluResult = rs1Value | operandB;
      pipelinePkg::AluXor: aluResult = rs1Value ^ operandB;
      pipelinePkg::AluSlt: aluResult = isaPkg::XLEN'($signed(rs1Value) < $signed(operandB));
      pipelinePkg::AluSltu: aluResult = isaPkg::XLEN'(rs1Value < operandB);
      pipelinePkg::AluSll: aluResult = rs1Value << shamt;
      pipelinePkg::AluSrl: aluResult = rs1Value >> shamt;
      pipelinePkg::AluSra: aluResult = $unsigned($signed(rs1Value) >>> shamt);
      default: aluResult = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    memAluResult <= aluResult;
    memWriteData <= rs2Value;
    memWriteIndex <= exWriteIndex;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      memMemWrite <= 1'b0;
      memMemRead <= 1'b0;
      memMemToReg <= 1'b0;
      memRegWrite <= 1'b0;
    end else begin
      memMemWrite <= exMemWrite;
      memMemRead <= exMemRead;
      memMemToReg <= exMemToReg;
      memRegWrite <= exRegWrite;
    end
  end

endmodule

// File: logic/WritebackStage.sv
`timescale 1ns/1ns

module WritebackStage (
  input  logic clk,
  input  logic rstN,
  input  logic [isaPkg::XLEN-1:0] memReadData,
  input  logic [isaPkg::XLEN-1:0] memAluResult,
  input  logic [isaPkg::REG_INDEX_WIDTH-1:0] memWriteIndex,
  input  logic memMemToReg,
  input  logic memRegWrite,
  output logic [isaPkg::XLEN-1:0] wbData,
  output logic [isaPkg::REG_INDEX_WIDTH-1:0] wbWriteIndex,
  output logic wbRegWrite
);

  logic [isaPkg::XLEN-1:0] wbReadData;
  logic [isaPkg::XLEN-1:0] wbAluResult;
  logic wbMemToReg;

  always_ff @(posedge clk) begin
    wbReadData <= memReadData;
    wbAluResult <= memAluResult;
    wbWriteIndex <= memWriteIndex;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wbMemToReg <= 1'b0;
      wbRegWrite <= 1'b0;
    end else begin
      wbMemToReg <= memMemToReg;
      wbRegWrite <= memRegWrite;
    end
  end

  assign wbData = wbMemToReg ? wbReadData : wbAluResult;

endmodule

// File: logic/CPU.sv
`timescale 1ns/1ns

module CPU (
  input  logic clk,
  input  logic rstN,
  input  logic progWriteEnable,
  input  logic [pipelinePkg::IMEM_ADDR_WIDTH-1:0] progAddress,
  input  logic [isaPkg::XLEN-1:0] progData,
  output logic retireValid,
  output logic [isaPkg::REG_INDEX_WIDTH-1:0] retireIndex,
  output logic [isaPkg::XLEN-1:0] retireData
);

  logic stall;
  logic [isaPkg::XLEN-1:0] pc;
  logic [isaPkg::XLEN-1:0] instruction;
  logic [isaPkg::XLEN-1:0] idInstruction;
  logic [isaPkg::REG_INDEX_WIDTH-1:0] rs1Index;
  logic [isaPkg::REG_INDEX_WIDTH-1:0] rs2Index;
  logic [isaPkg::XLEN-1:0] rs1Data;
  logic [isaPkg::XLEN-1:0] rs2Data;

  logic [isaPkg::XLEN-1:0] exRs1Data;
  logic [isaPkg::XLEN-1:0] exRs2Data;
  logic [isaPkg::REG_INDEX_WIDTH-1:0] exRs1Index;
  logic [isaPkg::REG_INDEX_WIDTH-1:0] exRs2Index;
  logic [isaPkg::REG_INDEX_WIDTH-1:0] exWriteIndex;
  logic [isaPkg::XLEN-1:0] exImmediate;
  logic [isaPkg::FUNCT3_WIDTH-1:0] exFunct3;
  logic [isaPkg::FUNCT7_WIDTH-1:0] exFunct7;
  pipelinePkg::aluOpT exAluOp;
  logic exAluSrc;
  logic exMemRead;
  logic exMemWrite;
  logic exMemToReg;
  logic exRegWrite;

  logic [isaPkg::XLEN-1:0] memAluResult;
  logic [isaPkg::XLEN-1:0] memWriteData;
  logic [isaPkg::REG_INDEX_WIDTH-1:0] memWriteIndex;
  logic memMemWrite;
  logic memMemRead;
  logic memMemToReg;
  logic memRegWrite;
  logic [isaPkg::XLEN-1:0] memReadData;

  MemoryHandler u_MemoryHandler (
    .clk(clk),
    .progWriteEnable(progWriteEnable),
    .progAddress(progAddress),
    .progData(progData),
    .pc(pc),
    .instruction(instruction),
    .dataAddress(memAluResult),
    .dataWriteData(memWriteData),
    .dataWriteEnable(memMemWrite),
    .dataReadEnable(memMemRead),
    .dataReadData(memReadData)
  );

  FetchStage u_FetchStage (
    .clk(clk),
    .rstN(rstN),
    .stall(stall),
    .instruction(instruction),
    .pc(pc),
    .idInstruction(idInstruction)
  );

  DecodeStage u_DecodeStage (
    .clk(clk),
    .rstN(rstN),
    .idInstruction(idInstruction),
    .rs1Index(rs1Index),
    .rs2Index(rs2Index),
    .rs1Data(rs1Data),
    .rs2Data(rs2Data),
    .exWriteIndexFeedback(exWriteIndex),
    .exMemReadFeedback(exMemRead),
    .stall(stall),
    .exRs1Data(exRs1Data),
    .exRs2Data(exRs2Data),
    .exRs1Index(exRs1Index),
    .exRs2Index(exRs2Index),
    .exWriteIndex(exWriteIndex),
    .exImmediate(exImmediate),
    .exFunct3(exFunct3),
    .exFunct7(exFunct7),
    .exAluOp(exAluOp),
    .exAluSrc(exAluSrc),
    .exMemRead(exMemRead),
    .exMemWrite(exMemWrite),
    .exMemToReg(exMemToReg),
    .exRegWrite(exRegWrite)
  );

  // Writeback drives the retire port directly
  RegisterFile u_RegisterFile (
    .clk(clk),
    .rstN(rstN),
    .rs1Index(rs1Index),
    .rs2Index(rs2Index),
    .rs1Data(rs1Data),
    .rs2Data(rs2Data),
    .writeIndex(retireIndex),
    .writeData(retireData),
    .writeEnable(retireValid)
  );

  ExecuteStage u_ExecuteStage (
    .clk(clk),
    .rstN(rstN),
    .exRs1Data(exRs1Data),
    .exRs2Data(exRs2Data),
    .exRs1Index(exRs1Index),
    .exRs2Index(exRs2Index),
    .exWriteIndex(exWriteIndex),
    .exImmediate(exImmediate),
    .exFunct3(exFunct3),
    .exFunct7(exFunct7),
    .exAluOp(exAluOp),
    .exAluSrc(exAluSrc),
    .exMemRead(exMemRead),
    .exMemWrite(exMemWrite),
    .exMemToReg(exMemToReg),
    .exRegWrite(exRegWrite),
    .wbData(retireData),
    .wbWriteIndex(retireIndex),
    .wbRegWrite(retireValid),
    .memAluResult(memAluResult),
    .memWriteData(memWriteData),
    .memWriteIndex(memWriteIndex),
    .memMemWrite(memMemWrite),
    .memMemRead(memMemRead),
    .memMemToReg(memMemToReg),
    .memRegWrite(memRegWrite)
  );

  WritebackStage u_WritebackStage (
    .clk(clk),
    .rstN(rstN),
    .memReadData(memReadData),
    .memAluResult(memAluResult),
    .memWriteIndex(memWriteIndex),
    .memMemToReg(memMemToReg),
    .memRegWrite(memRegWrite),
    .wbData(retireData),
    .wbWriteIndex(retireIndex),
    .wbRegWrite(retireValid)
  );

endmodule

// File: test/CpuTb.sv
`timescale 1ns/1ns

module CpuTb;

  localparam int RESET_CYCLES = 4;
  localparam int DRAIN_CYCLES = 12;
  localparam int RUN_MARGIN = 64;
  // Word 0 is fetched on the first edge after reset and retires four edges later
  localparam int FIRST_RETIRE_CYCLE = 5;
  localparam int RANDOM_LENGTH = 200;

  logic clk;
  logic rstN;
  logic progWriteEnable;
  logic [pipelinePkg::IMEM_ADDR_WIDTH-1:0] progAddress;
  logic [isaPkg::XLEN-1:0] progData;
  logic retireValid;
  logic [isaPkg::REG_INDEX_WIDTH-1:0] retireIndex;
  logic [isaPkg::XLEN-1:0] retireData;

  logic [31:0] progWords [$];
  logic [4:0] expIndex [$];
  logic [31:0] expData [$];
  logic [4:0] wantIndex;
  logic [31:0] wantData;
  string currentTest = "none";
  logic [31:0] rngState = 32'hd55c_eee0;
  int sinceReset = 0;
  int cycleCount = 0;
  int cycleLimit = RUN_MARGIN;
  int valueErrors = 0;
  int retireErrors = 0;
  int runErrors = 0;

  CPU u_CPU (
    .clk(clk),
    .rstN(rstN),
    .progWriteEnable(progWriteEnable),
    .progAddress(progAddress),
    .progData(progData),
    .retireValid(retireValid),
    .retireIndex(retireIndex),
    .retireData(retireData)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function automatic int pickBelow(input int n);
    return int'(nextRandom() % n);
  endfunction

  function automatic void emitR(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                                input logic [4:0] rs1, input logic [4:0] rs2);
    progWords.push_back({alt ? isaPkg::FUNCT7_ALT : 7'b0, rs2, rs1, f3, rd, isaPkg::OpRType});
  endfunction

  function automatic void emitI(input logic [6:0] opcode, input logic [2:0] f3,
                                input logic [4:0] rd, input logic [4:0] rs1,
                                input logic [11:0] imm);
    progWords.push_back({imm, rs1, f3, rd, opcode});
  endfunction

  function automatic void emitStore(input logic [4:0] rs2, input logic [4:0] rs1,
                                    input logic [11:0] imm);
    progWords.push_back({imm[11:5], rs2, rs1, isaPkg::FUNCT3_WORD, imm[4:0], isaPkg::OpStore});
  endfunction

  // RV32I semantics of one ALU operation
  function automatic logic [31:0] isaResult(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] signedA;
    signedA = a;
    case (f3)
      isaPkg::FUNCT3_ADD_SUB: return alt ? a - b : a + b;
      isaPkg::FUNCT3_SLL: return a << b[4:0];
      isaPkg::FUNCT3_SLT: return {31'b0, $signed(a) < $signed(b)};
      isaPkg::FUNCT3_SLTU: return {31'b0, a < b};
      isaPkg::FUNCT3_XOR: return a ^ b;
      isaPkg::FUNCT3_SRL_SRA: begin
        if (alt) begin
          return signedA >>> b[4:0];
        end
        return a >> b[4:0];
      end
      isaPkg::FUNCT3_OR: return a | b;
      default: return a & b;
    endcase
  endfunction

  // Runs the program in order and queues every nonzero register write
  function automatic int computeExpected();
    logic [31:0] regs [32];
    logic [31:0] mem [pipelinePkg::DMEM_DEPTH];
    logic [31:0] inst;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] addr;
    logic [31:0] result;
    logic [4:0] rd;
    logic [2:0] f3;
    logic alt;
    logic writes;
    int loads;
    loads = 0;
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    for (int i = 0; i < progWords.size(); i++) begin
      inst = progWords[i];
      rd = inst[11:7];
      f3 = inst[14:12];
      alt = inst[31:25] == isaPkg::FUNCT7_ALT;
      immI = {{20{inst[31]}}, inst[31:20]};
      immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      writes = 1'b1;
      result = '0;
      case (inst[6:0])
        isaPkg::OpRType: result = isaResult(f3, alt, regs[inst[19:15]], regs[inst[24:20]]);
        isaPkg::OpIType: begin
          // Only srai carries the alternate funct7
          alt = alt && (f3 == isaPkg::FUNCT3_SRL_SRA);
          result = isaResult(f3, alt, regs[inst[19:15]], immI);
        end
        isaPkg::OpLoad: begin
          addr = regs[inst[19:15]] + immI;
          result = mem[addr[9:2]];
          loads++;
        end
        isaPkg::OpStore: begin
          addr = regs[inst[19:15]] + immS;
          mem[addr[9:2]] = regs[inst[24:20]];
          writes = 1'b0;
        end
        default: writes = 1'b0;
      endcase
      if (writes && (rd != 5'd0)) begin
        regs[rd] = result;
        expIndex.push_back(rd);
        expData.push_back(result);
      end
    end
    return loads;
  endfunction

  function automatic void buildNopProgram();
    for (int i = 0; i < 8; i++) begin
      progWords.push_back(isaPkg::NOP_INSTRUCTION);
    end
  endfunction

  // Each result feeds the next ones at distance 1, 2 and 3
  function automatic void buildAluChain();
    emitI(isaPkg::OpIType, isaPkg::FUNCT3_ADD_SUB, 5'd1, 5'd0, 12'd5);
    emitI(isaPkg::OpIType, isaPkg::FUNCT3_ADD_SUB, 5'd2, 5'd0, 12'hffd);
    emitR(isaPkg::FUNCT3_ADD_SUB, 1'b0, 5'd3, 5'd1, 5'd2);
    emitR(isaPkg::FUNCT3_ADD_SUB, 1'b1, 5'd4, 5'd3, 5'd1);
    emitR(isaPkg::FUNCT3_XOR, 1'b0, 5'd5, 5'd4, 5'd3);
    emitI(isaPkg::OpIType, isaPkg::FUNCT3_SLL, 5'd6, 5'd5, 12'd3);
    emitR(isaPkg::FUNCT3_OR, 1'b0, 5'd7, 5'd6, 5'd5);
    emitR(isaPkg::FUNCT3_SRL_SRA, 1'b1, 5'd2, 5'd7, 5'd1);
    emitR(isaPkg::FUNCT3_SRL_SRA, 1'b0, 5'd3, 5'd7, 5'd1);
    emitR(isaPkg::FUNCT3_SLT, 1'b0, 5'd4, 5'd2, 5'd3);
    emitR(isaPkg::FUNCT3_SLTU, 1'b0, 5'd5, 5'd2, 5'd3);
    emitR(isaPkg::FUNCT3_AND, 1'b0, 5'd6, 5'd7, 5'd2);
    emitR(isaPkg::FUNCT3_SLL, 1'b0, 5'd3, 5'd6, 5'd1);
    emitI(isaPkg::OpIType, isaPkg::FUNCT3_XOR, 5'd7, 5'd6, 12'h5a5);
    emitI(isaPkg::OpIType, isaPkg::FUNCT3_OR, 5'd1, 5'd7, 12'h0f0);
    emitI(isaPkg::OpIType, isaPkg::FUNCT3_AND, 5'd2, 5'd1, 12'hfff);
    emitI(isaPkg::OpIType, isaPkg::FUNCT3_SLT, 5'd3, 5'd2, 12'hfff);
    emitI(isaPkg::OpIType, isaPkg::FUNCT3_SLTU, 5'd4, 5'd2, 12'h7ff);
    emitI(isaPkg::OpIType, isaPkg::FUNCT3_SRL_SRA, 5'd5, 5'd2, {isaPkg::FUNCT7_ALT, 5'd2});
    emitI(isaPkg::OpIType, isaPkg::FUNCT3_SRL_SRA, 5'd6, 5'd5, 12'd1);
  endfunction

  function automatic void buildLoadUse();
    emitI(isaPkg::OpIType, isaPkg::FUNCT3_ADD_SUB, 5'd1, 5'd0, 12'h100);
    emitI(isaPkg::OpIType, isaPkg::FUNCT3_ADD_SUB, 5'd2, 5'd0, 12'd77);
    emitStore(5'd2, 5'd1, 12'd0);
    emitI(isaPkg::OpLoad, isaPkg::FUNCT3_WORD, 5'd3, 5'd1, 12'd0);
    emitR(isaPkg::FUNCT3_ADD_SUB, 1'b0, 5'd4, 5'd3, 5'd2);
    emitI(isaPkg::OpLoad, isaPkg::FUNCT3_WORD, 5'd5, 5'd1, 12'd0);
    // Store data depends on the load just before it
    emitStore(5'd5, 5'd1, 12'd4);
    emitI(isaPkg::OpLoad, isaPkg::FUNCT3_WORD, 5'd6, 5'd1, 12'd4);
    emitR(isaPkg::FUNCT3_ADD_SUB, 1'b0, 5'd7, 5'd6, 5'd6);
  endfunction

  function automatic void buildStoreLoad();
    emitI(isaPkg::OpIType, isaPkg::FUNCT3_ADD_SUB, 5'd1, 5'd0, 12'h200);
    emitI(isaPkg::OpIType, isaPkg::FUNCT3_ADD_SUB, 5'd2, 5'd0, 12'h123);
    emitI(isaPkg::OpIType, isaPkg::FUNCT3_ADD_SUB, 5'd3, 5'd0, 12'hbaa);
    emitI(isaPkg::OpIType, isaPkg::FUNCT3_XOR, 5'd4, 5'd3, 12'h7ff);
    emitI(isaPkg::OpIType, isaPkg::FUNCT3_ADD_SUB, 5'd5, 5'd0, 12'd1);
    for (int k = 0; k < 4; k++) begin
      emitStore(5'(k + 2), 5'd1, 12'(4 * k));
    end
    emitR(isaPkg::FUNCT3_ADD_SUB, 1'b0, 5'd0, 5'd2, 5'd3);
    emitI(isaPkg::OpLoad, isaPkg::FUNCT3_WORD, 5'd6, 5'd1, 12'd0);
    emitI(isaPkg::OpLoad, isaPkg::FUNCT3_WORD, 5'd7, 5'd1, 12'd4);
    emitI(isaPkg::OpLoad, isaPkg::FUNCT3_WORD, 5'd2, 5'd1, 12'd8);
    emitI(isaPkg::OpLoad, isaPkg::FUNCT3_WORD, 5'd3, 5'd1, 12'd12);
    emitI(isaPkg::OpLoad, isaPkg::FUNCT3_WORD, 5'd0, 5'd1, 12'd4);
    emitR(isaPkg::FUNCT3_ADD_SUB, 1'b0, 5'd4, 5'd6, 5'd7);
  endfunction

  // x1 stays the base of eight data words that the prologue fills
  function automatic void buildRandomProgram();
    int kind;
    logic [2:0] f3;
    logic [4:0] rd;
    logic alt;
    logic [11:0] imm;
    emitI(isaPkg::OpIType, isaPkg::FUNCT3_ADD_SUB, 5'd1, 5'd0, 12'h300);
    for (int r = 2; r < 8; r++) begin
      emitI(isaPkg::OpIType, isaPkg::FUNCT3_ADD_SUB, 5'(r), 5'd0, 12'(nextRandom()));
    end
    for (int k = 0; k < 8; k++) begin
      emitStore(5'(2 + k % 6), 5'd1, 12'(4 * k));
    end
    while (progWords.size() < RANDOM_LENGTH) begin
      kind = pickBelow(8);
      f3 = 3'(pickBelow(8));
      rd = 5'(2 + pickBelow(6));
      alt = pickBelow(2) == 1;
      imm = 12'(nextRandom());
      if (kind < 3) begin
        alt = alt && ((f3 == isaPkg::FUNCT3_ADD_SUB) || (f3 == isaPkg::FUNCT3_SRL_SRA));
        emitR(f3, alt, rd, 5'(pickBelow(8)), 5'(pickBelow(8)));
      end else if (kind < 6) begin
        if (f3 == isaPkg::FUNCT3_SLL) begin
          imm = {7'b0, imm[4:0]};
        end else if (f3 == isaPkg::FUNCT3_SRL_SRA) begin
          imm = {alt ? isaPkg::FUNCT7_ALT : 7'b0, imm[4:0]};
        end
        emitI(isaPkg::OpIType, f3, rd, 5'(pickBelow(8)), imm);
      end else if (kind == 6) begin
        emitI(isaPkg::OpLoad, isaPkg::FUNCT3_WORD, rd, 5'd1, 12'(4 * pickBelow(8)));
      end else begin
        emitStore(5'(pickBelow(8)), 5'd1, 12'(4 * pickBelow(8)));
      end
    end
  endfunction

  // Loads the program under reset, then waits for every expected retire
  task automatic runTest(input string name);
    int progLen;
    int loadCount;
    int totalWords;
    int budget;
    int waited;
    currentTest = name;
    @(posedge clk);
    rstN <= 1'b0;
    loadCount = computeExpected();
    progLen = progWords.size();
    // Nop padding covers the stall cycles and the drain
    totalWords = progLen + loadCount + 16;
    assert (totalWords <= pipelinePkg::IMEM_DEPTH) else begin
      runErrors++;
      $display("%s: program of %0d words does not fit in instruction memory", name, totalWords);
      totalWords = pipelinePkg::IMEM_DEPTH;
    end
    budget = progLen + loadCount + 16;
    cycleLimit += totalWords + RESET_CYCLES + budget + DRAIN_CYCLES + 2;
    for (int i = 0; i < totalWords; i++) begin
      @(posedge clk);
      progWriteEnable <= 1'b1;
      progAddress <= pipelinePkg::IMEM_ADDR_WIDTH'(i);
      progData <= (i < progLen) ? progWords[i] : isaPkg::NOP_INSTRUCTION;
    end
    @(posedge clk);
    progWriteEnable <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rstN <= 1'b1;
    waited = 0;
    while ((expIndex.size() != 0) && (waited < budget)) begin
      @(posedge clk);
      waited++;
    end
    assert (expIndex.size() == 0) else begin
      runErrors++;
      $display("%s: %0d expected register writes never retired", name, expIndex.size());
    end
    repeat (DRAIN_CYCLES) @(posedge clk);
    expIndex.delete();
    expData.delete();
    progWords.delete();
  endtask

  // Retire monitor samples the port on the rising edge
  always @(posedge clk) begin
    if (!rstN) begin
      sinceReset = 0;
      assert (retireValid !== 1'b1) else begin
        retireErrors++;
        $display("%s: retire pulse while reset was asserted", currentTest);
      end
    end else begin
      sinceReset++;
      if (retireValid === 1'b1) begin
        assert (sinceReset >= FIRST_RETIRE_CYCLE) else begin
          retireErrors++;
          $display("%s: retire pulse before the first instruction reached writeback",
                   currentTest);
        end
        assert (expIndex.size() != 0) else begin
          retireErrors++;
          $display("%s: unexpected retire of x%0d beyond the expected list", currentTest,
                   retireIndex);
        end
        if (expIndex.size() != 0) begin
          wantIndex = expIndex.pop_front();
          wantData = expData.pop_front();
          assert ((retireIndex == wantIndex) && (retireData == wantData)) else begin
            valueErrors++;
            $display("ERR %s: expected x%0d = %08h, actual x%0d = %08h", currentTest,
                     wantIndex, wantData, retireIndex, retireData);
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Timeout after %0d cycles: value errors %0d, retire errors %0d, run errors %0d",
               cycleCount, valueErrors, retireErrors, runErrors);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    rstN = 1'b0;
    progWriteEnable = 1'b0;
    progAddress = '0;
    progData = '0;
    buildNopProgram();
    runTest("resetNop");
    buildAluChain();
    runTest("aluChain");
    buildLoadUse();
    runTest("loadUse");
    buildStoreLoad();
    runTest("storeLoad");
    buildRandomProgram();
    runTest("randomProgram");
    $display("Value errors %0d, retire errors %0d, run errors %0d",
             valueErrors, retireErrors, runErrors);
    if ((valueErrors == 0) && (retireErrors == 0) && (runErrors == 0)) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: sources.f
logic/isaPkg.sv
logic/pipelinePkg.sv
logic/ForwardingUnit.sv
logic/RegisterFile.sv
logic/MemoryHandler.sv
logic/FetchStage.sv
logic/DecodeStage.sv
logic/ExecuteStage.sv
logic/WritebackStage.sv
logic/CPU.sv
test/CpuTb.sv

// File: Makefile
# Verilator build and run for the pipelined RV32I core

VERILATOR ?= verilator
TOP ?= CpuTb
RTL_TOP ?= CPU
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= Verification passed
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail
run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
